// File: hw/soundCartPkg.sv
package soundCartPkg;

    // slot bus as seen from the cartridge pins, all strobes active low
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dataIn;
        logic        rdN;
        logic        wrN;
        logic        merqN;
        logic        iorqN;
        logic        sltslN;
    } cpuBus_t;

    typedef struct packed {
        logic [7:0] dataOut;
        logic       busDirN;  // low while we drive the data bus
    } busResp_t;

    // decoder to tone source
    typedef struct packed {
        logic       csN;
        logic       regAddr;  // 0 index port, 1 data port
        logic       wrStrobe; // single-cycle pulse
        logic [7:0] data;
    } toneSel_t;

    typedef enum logic [1:0] {
        MELODY_PERIOD = 2'd0,
        MELODY_LEVEL  = 2'd1,
        RHYTHM_PERIOD = 2'd2,
        RHYTHM_LEVEL  = 2'd3
    } toneReg_e;

    typedef enum logic [1:0] {
        RD_NONE,
        RD_IOSW,
        RD_SRAM
    } readSrc_e;

    localparam logic [7:0]  IO_BASE       = 8'h7C;    // ports 7Ch/7Dh
    localparam logic [15:0] MIO_BASE      = 16'h7FF4; // mem-mapped 7FF4h/7FF5h
    localparam logic [15:0] IOSW_ADDR     = 16'h7FF6;
    localparam logic [15:0] SRAM_BASE     = 16'h4000;
    localparam logic [15:0] SRAM_KEY_ADDR = 16'h5FFE;
    localparam logic [7:0]  SRAM_KEY0     = 8'h4D;
    localparam logic [7:0]  SRAM_KEY1     = 8'h69;

    localparam int SAMPLE_WIDTH = 10;
    localparam int LPF_DEPTH    = 16;
    localparam int LPF_SHIFT    = 4;  // log2 of LPF_DEPTH
    localparam int LEVEL_SCALE  = 32; // amplitude per level step

endpackage

// File: hw/cartBusDecoder.sv
`timescale 1ns/1ps

module cartBusDecoder (
    input  logic                   CLK,
    input  logic                   RESET_n,
    input  soundCartPkg::cpuBus_t  bus,
    output soundCartPkg::busResp_t resp,
    output soundCartPkg::toneSel_t toneSel
);

    logic memRdN;
    logic memWrN;
    logic ioWrN;
    logic prevMemWrN;
    logic prevIoWrN;
    logic memWrEdge;
    logic ioWrEdge;

    logic ioswCsN;
    logic keyCsN;
    logic sramCsN;
    logic sramEn;
    logic ioToneCsN;
    logic memToneCsN;

    logic [7:0] ioswReg;
    logic [7:0] sramKey [2];

    soundCartPkg::readSrc_e readSrc;

    // memory cycles need the slot select, I/O cycles don't
    assign memRdN = bus.rdN | bus.merqN | bus.sltslN;
    assign memWrN = bus.wrN | bus.merqN | bus.sltslN;
    assign ioWrN  = bus.wrN | bus.iorqN;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            prevMemWrN <= 1'b1;
            prevIoWrN  <= 1'b1;
        end else begin
            prevMemWrN <= memWrN;
            prevIoWrN  <= ioWrN;
        end
    end

    assign memWrEdge = prevMemWrN & ~memWrN; // high only in first low cycle
    assign ioWrEdge  = prevIoWrN & ~ioWrN;

    // address decode
    assign ioswCsN = (bus.addr != soundCartPkg::IOSW_ADDR);
    assign keyCsN  = (bus.addr[15:1] != soundCartPkg::SRAM_KEY_ADDR[15:1]);
    assign sramEn  = (sramKey[0] == soundCartPkg::SRAM_KEY0) &&
                     (sramKey[1] == soundCartPkg::SRAM_KEY1);
    assign sramCsN = (bus.addr[15:13] != soundCartPkg::SRAM_BASE[15:13]) | ~sramEn;

    // switch register, bit 0 opens the I/O ports
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            ioswReg <= 8'h00;
        end else if (memWrEdge && !ioswCsN) begin
            ioswReg <= bus.dataIn;
        end
    end

    // two-byte signature, any mismatch closes the window again
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            sramKey[0] <= 8'h00;
            sramKey[1] <= 8'h00;
        end else if (memWrEdge && !keyCsN) begin
            sramKey[bus.addr[0]] <= bus.dataIn;
        end
    end

    // read source select
    always_comb begin
        if (memRdN) begin
            readSrc = soundCartPkg::RD_NONE;
        end else if (!ioswCsN) begin
            readSrc = soundCartPkg::RD_IOSW;
        end else if (!sramCsN) begin
            readSrc = soundCartPkg::RD_SRAM; // no array behind it, reads 0
        end else begin
            readSrc = soundCartPkg::RD_NONE;
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            resp.dataOut <= 8'h00;
            resp.busDirN <= 1'b1;
        end else begin
            case (readSrc)
                soundCartPkg::RD_IOSW: begin
                    resp.dataOut <= ioswReg;
                    resp.busDirN <= 1'b0;
                end
                soundCartPkg::RD_SRAM: begin
                    resp.dataOut <= 8'h00;
                    resp.busDirN <= 1'b0;
                end
                default: begin
                    resp.dataOut <= 8'h00;
                    resp.busDirN <= 1'b1; // bus left alone
                end
            endcase
        end
    end

    // tone source chip selects
    assign ioToneCsN  = (bus.addr[7:1] != soundCartPkg::IO_BASE[7:1]) | bus.iorqN | ~ioswReg[0];
    assign memToneCsN = (bus.addr[15:1] != soundCartPkg::MIO_BASE[15:1]) | bus.merqN
                        | bus.sltslN;

    assign toneSel.csN      = ioToneCsN & memToneCsN;
    assign toneSel.regAddr  = bus.addr[0];
    assign toneSel.wrStrobe = (memWrEdge & ~memToneCsN) | (ioWrEdge & ~ioToneCsN);
    assign toneSel.data     = bus.dataIn;

    // once the read strobe has been gone for a full cycle we must have released the bus
    assert property (@(posedge CLK) disable iff (!RESET_n)
        bus.rdN && $past(bus.rdN) |-> resp.busDirN);

endmodule

// File: hw/toneSource.sv
`timescale 1ns/1ps

module toneSource (
    input  logic                                        CLK,
    input  logic                                        RESET_n,
    input  soundCartPkg::toneSel_t                      toneSel,
    input  logic                                        sampleEn,
    output logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] melody,
    output logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] rhythm
);

    soundCartPkg::toneReg_e regIdx;

    logic [7:0] toneRegs [4]; // indexed by toneReg_e
    logic       idxWr;
    logic       dataWr;

    logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] chanSample [2];

    assign idxWr  = toneSel.wrStrobe & ~toneSel.csN & ~toneSel.regAddr;
    assign dataWr = toneSel.wrStrobe & ~toneSel.csN & toneSel.regAddr;

    // index port
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            regIdx <= soundCartPkg::MELODY_PERIOD;
        end else if (idxWr) begin
            regIdx <= soundCartPkg::toneReg_e'(toneSel.data[1:0]); // upper bits ignored
        end
    end

    // data port
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < 4; i++) begin
                toneRegs[i] <= 8'h00;
            end
        end else if (dataWr) begin
            toneRegs[regIdx] <= toneSel.data;
        end
    end

    // channel 0 melody, channel 1 rhythm
    for (genvar c = 0; c < 2; c++) begin : gChan
        logic [7:0] period;
        logic [7:0] level;
        logic [7:0] halfCnt;
        logic [7:0] halfCntNext;
        logic       phase;     // 1 = high half
        logic       phaseNext;
        logic       posSide;
        logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] amp;

        assign period = (c == 0) ? toneRegs[soundCartPkg::MELODY_PERIOD]
                                 : toneRegs[soundCartPkg::RHYTHM_PERIOD];
        assign level  = (c == 0) ? toneRegs[soundCartPkg::MELODY_LEVEL]
                                 : toneRegs[soundCartPkg::RHYTHM_LEVEL];

        always_comb begin
            if (period == 8'd0) begin
                halfCntNext = 8'd0; // dc output
                phaseNext   = 1'b1;
            end else if (halfCnt >= period - 8'd1) begin
                halfCntNext = 8'd0;
                phaseNext   = ~phase;
            end else begin
                halfCntNext = halfCnt + 8'd1;
                phaseNext   = phase;
            end
        end

        assign amp     = soundCartPkg::SAMPLE_WIDTH'(level[3:0] * soundCartPkg::LEVEL_SCALE);
        assign posSide = phaseNext ^ level[7]; // bit 7 flips polarity

        always_ff @(posedge CLK or negedge RESET_n) begin
            if (!RESET_n) begin
                halfCnt        <= 8'd0;
                phase          <= 1'b1;
                chanSample[c]  <= '0;
            end else if (sampleEn) begin
                halfCnt        <= halfCntNext;
                phase          <= phaseNext;
                chanSample[c]  <= posSide ? amp : -amp;
            end
        end
    end

    assign melody = chanSample[0];
    assign rhythm = chanSample[1];

    // software selects only the four implemented registers
    assert property (@(posedge CLK) disable iff (!RESET_n)
        idxWr |-> (toneSel.data < 8'd4));

endmodule

// File: hw/movingAvgLpf.sv
`timescale 1ns/1ps

module movingAvgLpf (
    input  logic                                        CLK,
    input  logic                                        RESET_n,
    input  logic                                        sampleEn,
    input  logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] sampleIn,
    output logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] sampleOut
);

    // window of LPF_DEPTH samples with LPF_SHIFT guard bits on the sum
    logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] sampleBuf [soundCartPkg::LPF_DEPTH];

    logic signed [soundCartPkg::SAMPLE_WIDTH+soundCartPkg::LPF_SHIFT-1:0] sum;
    logic signed [soundCartPkg::SAMPLE_WIDTH+soundCartPkg::LPF_SHIFT-1:0] sumNext;
    logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] evicted;

    logic [soundCartPkg::LPF_SHIFT-1:0] wrIdx;   // wraps on its own
    logic [soundCartPkg::LPF_SHIFT:0]   fillCnt;
    logic                               full;

    assign full = (fillCnt == soundCartPkg::LPF_DEPTH);

    // oldest entry is only meaningful once every slot has been written
    assign evicted = full ? sampleBuf[wrIdx] : '0;
    assign sumNext = sum + sampleIn - evicted;

    // buffer storage
    always_ff @(posedge CLK) begin
        if (sampleEn) begin
            sampleBuf[wrIdx] <= sampleIn;
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            wrIdx   <= '0;
            fillCnt <= '0;
            sum     <= '0;
        end else if (sampleEn) begin
            wrIdx <= wrIdx + 1'b1;
            sum   <= sumNext;
            if (!full) begin
                fillCnt <= fillCnt + 1'b1; // saturates at depth
            end
        end
    end

    // arithmetic shift keeps the sign of the average
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            sampleOut <= '0;
        end else begin
            sampleOut <= soundCartPkg::SAMPLE_WIDTH'(sum >>> soundCartPkg::LPF_SHIFT);
        end
    end

    // fill count never passes the window depth
    assert property (@(posedge CLK) disable iff (!RESET_n)
        fillCnt <= soundCartPkg::LPF_DEPTH);

endmodule

// File: hw/audioMixer.sv
`timescale 1ns/1ps

module audioMixer (
    input  logic                                        CLK,
    input  logic                                        RESET_n,
    input  logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] melodyIn,
    input  logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] rhythmIn,
    output logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] soundOut
);

    logic signed [soundCartPkg::SAMPLE_WIDTH:0]   mixSum; // one extra bit, cannot wrap
    logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] mixSat;
    logic                                         ovf;

    assign mixSum = {melodyIn[soundCartPkg::SAMPLE_WIDTH-1], melodyIn}
                  + {rhythmIn[soundCartPkg::SAMPLE_WIDTH-1], rhythmIn};

    // top two bits differ -> out of range
    assign ovf = mixSum[soundCartPkg::SAMPLE_WIDTH] ^ mixSum[soundCartPkg::SAMPLE_WIDTH-1];

    always_comb begin
        if (ovf) begin
            // clamp toward the sign, -512 or +511
            mixSat = {mixSum[soundCartPkg::SAMPLE_WIDTH],
                      {(soundCartPkg::SAMPLE_WIDTH-1){~mixSum[soundCartPkg::SAMPLE_WIDTH]}}};
        end else begin
            mixSat = mixSum[soundCartPkg::SAMPLE_WIDTH-1:0];
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            soundOut <= '0;
        end else begin
            soundOut <= mixSat;
        end
    end

endmodule

// File: hw/soundCartridge.sv
`timescale 1ns/1ps

module soundCartridge (
    input  logic                                         CLK,
    input  logic                                         RESET_n,
    input  logic                                         sampleEn, // one-cycle, from outside
    input  soundCartPkg::cpuBus_t                        bus,
    output soundCartPkg::busResp_t                       resp,
    output logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] soundOut
);

    soundCartPkg::toneSel_t toneSel;

    logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] melodyRaw;
    logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] rhythmRaw;
    logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] melodyLpf;
    logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] rhythmLpf;

    // slot decode and mapped registers
    cartBusDecoder decoder0 (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .bus     (bus),
        .resp    (resp),
        .toneSel (toneSel)
    );

    // stand-in for the FM chip
    toneSource tone0 (
        .CLK      (CLK),
        .RESET_n  (RESET_n),
        .toneSel  (toneSel),
        .sampleEn (sampleEn),
        .melody   (melodyRaw),
        .rhythm   (rhythmRaw)
    );

    movingAvgLpf melodyLpf0 (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .sampleEn  (sampleEn),
        .sampleIn  (melodyRaw),
        .sampleOut (melodyLpf)
    );

    movingAvgLpf rhythmLpf0 (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .sampleEn  (sampleEn),
        .sampleIn  (rhythmRaw),
        .sampleOut (rhythmLpf)
    );

    // saturating sum, registered
    audioMixer mixer0 (
        .CLK      (CLK),
        .RESET_n  (RESET_n),
        .melodyIn (melodyLpf),
        .rhythmIn (rhythmLpf),
        .soundOut (soundOut)
    );

endmodule

// File: dv/soundCartTb.sv
`timescale 1ns/1ps

module soundCartTb;

    logic                                         CLK;
    logic                                         RESET_n;
    logic                                         sampleEn;
    logic [1:0]                                   sampleCnt;
    soundCartPkg::cpuBus_t                        bus;
    soundCartPkg::busResp_t                       resp;
    logic signed [soundCartPkg::SAMPLE_WIDTH-1:0] soundOut;

    integer     seed;              // for random bytes on unmapped writes
    logic [7:0] ioswModel;         // switch register as the bus writes left it
    logic [1:0] toneIdxModel;
    logic [7:0] toneRegModel [4];  // melody period, melody level, rhythm period, rhythm level

    soundCartridge dut0 (
        .CLK      (CLK),
        .RESET_n  (RESET_n),
        .sampleEn (sampleEn),
        .bus      (bus),
        .resp     (resp),
        .soundOut (soundOut)
    );

    always #2 CLK = ~CLK; // 4 ns period

    // sample strobe on one clock in four
    always @(posedge CLK) begin
        if (!RESET_n) begin
            sampleCnt <= 2'd0;
            sampleEn  <= 1'b0;
        end else begin
            sampleCnt <= sampleCnt + 2'd1;
            sampleEn  <= (sampleCnt == 2'd3);
        end
    end

    task automatic failRun(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    // four-clock bus cycle of assert, hold, hold and release
    task automatic driveCycle(input logic isIo, input logic isRead, input logic [15:0] addr,
                              input logic [7:0] data, output logic [8:0] readBack);
        @(posedge CLK);
        bus.addr   <= addr;
        bus.dataIn <= data;
        bus.merqN  <= isIo;
        bus.iorqN  <= ~isIo;
        bus.sltslN <= isIo;     // slot select only on memory cycles
        bus.rdN    <= ~isRead;
        bus.wrN    <= isRead;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        readBack = {resp.busDirN, resp.dataOut}; // registered one clock after rdN low
        @(posedge CLK);
        bus.rdN    <= 1'b1;
        bus.wrN    <= 1'b1;
        bus.merqN  <= 1'b1;
        bus.iorqN  <= 1'b1;
        bus.sltslN <= 1'b1;
        @(posedge CLK);
        @(negedge CLK);
        if (isRead) begin
            assert (resp.busDirN) else failRun($sformatf(
                "error: %0t ns: busDirN still low one clock after read of %h ended", $time, addr));
        end
    endtask

    // register effects of a write per the memory map
    task automatic updateModel(input logic isIo, input logic [15:0] addr, input logic [7:0] data);
        if (!isIo) begin
            if (addr == soundCartPkg::IOSW_ADDR) begin
                ioswModel = data;
            end else if (addr == soundCartPkg::MIO_BASE) begin
                toneIdxModel = data[1:0];
            end else if (addr == soundCartPkg::MIO_BASE + 16'd1) begin
                toneRegModel[toneIdxModel] = data;
            end
        end else if (ioswModel[0]) begin // ports closed while bit 0 clear
            if (addr[7:0] == soundCartPkg::IO_BASE) begin
                toneIdxModel = data[1:0];
            end else if (addr[7:0] == soundCartPkg::IO_BASE + 8'd1) begin
                toneRegModel[toneIdxModel] = data;
            end
        end
    endtask

    // settled filter output of one channel
    function automatic int channelAverage(input logic [7:0] period, input logic [7:0] level);
        int amp;
        amp = level[3:0] * soundCartPkg::LEVEL_SCALE;
        if (period != 8'd0) begin
            return 0; // equal high and low counts in a full window
        end
        return level[7] ? -amp : amp;
    endfunction

    task automatic checkAudio(input logic [9:0] expectBits);
        int model;
        int fromFile;
        int got;
        for (int c = 0; c < 4; c += 2) begin
            if (toneRegModel[c] != 8'd0 &&
                (soundCartPkg::LPF_DEPTH % (2 * toneRegModel[c])) != 0) begin
                failRun("audio check on a tone period that does not fill the window evenly");
            end
        end
        model = channelAverage(toneRegModel[0], toneRegModel[1])
              + channelAverage(toneRegModel[2], toneRegModel[3]);
        if (model > 511) model = 511;   // mixer clamp
        if (model < -512) model = -512;
        fromFile = $signed(expectBits);
        assert (fromFile == model) else failRun($sformatf(
            "vectors file expects %0d where the tone registers give %0d", fromFile, model));
        @(negedge CLK);
        got = soundOut;
        assert (got == model) else failRun($sformatf(
            "error: %0t ns: soundOut is %0d, expected %0d", $time, got, model));
    endtask

    // count sample strobes within a clock budget
    task automatic waitSamples(input int count);
        int seen;
        int clocks;
        seen   = 0;
        clocks = 0;
        while (seen < count) begin
            @(negedge CLK);
            clocks++;
            if (sampleEn) seen++;
            if (clocks > 4 * count + 16) begin
                failRun("timeout: the sample strobe stopped arriving while waiting");
            end
        end
    endtask

    initial begin
        integer            fd;
        integer            code;
        logic [31:0]       op;
        logic [15:0]       addr;
        logic [7:0]        data;
        logic [15:0]       value;
        logic [8:0]        readBack;
        logic [8*128-1:0]  restOfLine;
        int                lineOps;

        CLK       = 1'b0;
        RESET_n   = 1'b0;
        sampleEn  = 1'b0;
        sampleCnt = 2'd0;
        bus       = '{addr: 16'h0000, dataIn: 8'h00, rdN: 1'b1, wrN: 1'b1,
                      merqN: 1'b1, iorqN: 1'b1, sltslN: 1'b1};
        seed         = 86;
        ioswModel    = 8'h00;
        toneIdxModel = 2'd0;
        lineOps      = 0;
        for (int i = 0; i < 4; i++) toneRegModel[i] = 8'h00;

        repeat (3) @(posedge CLK);
        RESET_n <= 1'b1;

        fd = $fopen("dv/soundCartVectors.txt", "r");
        if (fd == 0) failRun("could not open dv/soundCartVectors.txt");
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) break; // end of file
            if (op == "#") begin
                code = $fgets(restOfLine, fd); // comment line
                continue;
            end
            code = $fscanf(fd, "%h %h %h", addr, data, value);
            if (code != 3) begin
                failRun($sformatf("malformed vector line after %0d operations", lineOps));
            end
            case (op)
                "MW", "IW": begin
                    driveCycle(op == "IW", 1'b0, addr, data, readBack);
                    updateModel(op == "IW", addr, data);
                end
                "UW": begin
                    data = $random(seed);
                    driveCycle(1'b0, 1'b0, addr, data, readBack); // no register behind it
                end
                "MP", "IP": begin // index then data port
                    driveCycle(op == "IP", 1'b0, addr, data, readBack);
                    updateModel(op == "IP", addr, data);
                    driveCycle(op == "IP", 1'b0, addr + 16'd1, value[7:0], readBack);
                    updateModel(op == "IP", addr + 16'd1, value[7:0]);
                end
                "MR": begin
                    driveCycle(1'b0, 1'b1, addr, 8'h00, readBack);
                    assert (readBack == value[8:0]) else failRun($sformatf(
                        "error: %0t ns: read of %h gave busDirN %b data %h, expected %03h",
                        $time, addr, readBack[8], readBack[7:0], value[8:0]));
                end
                "ST": waitSamples(addr);
                "CA": checkAudio(value[9:0]);
                default: failRun($sformatf("unknown vector operation %s", op));
            endcase
            lineOps++;
        end
        $fclose(fd);
        assert (lineOps > 0) else failRun("no vectors were read from the file");

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: soundCartridge.f
hw/soundCartPkg.sv
hw/cartBusDecoder.sv
hw/toneSource.sv
hw/movingAvgLpf.sv
hw/audioMixer.sv
hw/soundCartridge.sv
dv/soundCartTb.sv

// File: dv/soundCartVectors.txt
# op addr data value, all hex. MW/IW write data, UW writes a random byte, MR expects {busDirN,dataOut}
# MP/IP write data as index to addr then value to addr+1, ST waits addr samples, CA expects soundOut
MW 7FF6 5A 000
UW 8000 00 000
UW 1234 00 000
MR 7FF6 00 05A
MR 1234 00 100
MR 4000 00 100
MW 5FFE 4D 000
MR 4000 00 100
MW 5FFF 69 000
MR 4000 00 000
MW 5FFF 12 000
MR 4000 00 100
# constant levels through 7FF4h/7FF5h, 960 clamps to 511
MP 7FF4 00 000
MP 7FF4 02 000
MP 7FF4 01 00F
MP 7FF4 03 00F
ST 0018 00 000
CA 0000 00 1FF
MP 7FF4 01 004
MP 7FF4 03 004
ST 0018 00 000
CA 0000 00 100
# invert bit set, -960 clamps to -512
MP 7FF4 01 08F
MP 7FF4 03 08F
ST 0018 00 000
CA 0000 00 200
# square waves 8 high 8 low, window averages out
MP 7FF4 00 008
MP 7FF4 02 008
MP 7FF4 01 00A
MP 7FF4 03 00A
ST 0028 00 000
CA 0000 00 000
ST 0003 00 000
CA 0000 00 000
ST 0005 00 000
CA 0000 00 000
# ports 7Ch/7Dh closed while switch bit 0 is clear
IP 007C 00 000
IP 007C 01 00F
ST 0018 00 000
CA 0000 00 000
MW 7FF6 01 000
IP 007C 00 000
IP 007C 02 000
IP 007C 01 003
IP 007C 03 005
ST 0018 00 000
CA 0000 00 100
MR 7FF6 00 001
